// ==== bundle_arbiter.sv ====
`default_nettype none

module bundle_arbiter import dma_pkg::*; (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic [1:0]             i_req,
  input  logic [1:0][ROW_AW-1:0] i_idx,
  input  bundle_row_u            i_row,
  output logic                   o_rd_en,
  output logic [ROW_AW-1:0]      o_rd_addr,
  output logic [1:0]             o_grant_valid,
  output bundle_fields_t         o_fields
);

  // pixels win, weights simply ask again next cycle
  assign o_rd_en   = |i_req;
  assign o_rd_addr = i_req[STREAM_X] ? i_idx[STREAM_X] : i_idx[STREAM_W];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_grant_valid <= '0;
    end else begin
      o_grant_valid <= '0;
      if (i_req[STREAM_X]) begin
        o_grant_valid[STREAM_X] <= 1'b1;
      end else if (i_req[STREAM_W]) begin
        o_grant_valid[STREAM_W] <= 1'b1;
      end
    end
  end

  assign o_fields = i_row.fields;  // one decode shared by both sequencers

  // a returning row has exactly one owner and follows a ram read
  a_one_owner: assert property (@(posedge clk) disable iff (!rstn)
    o_grant_valid != '0 |-> $onehot(o_grant_valid) && $past(o_rd_en));

endmodule

`default_nettype wire

// ==== bundle_ram.sv ====
`default_nettype none

module bundle_ram import dma_pkg::*; (
  input  logic               clk,
  input  logic               i_wr_en,
  input  logic [WORD_AW-1:0] i_wr_addr,
  input  logic [DATA_W-1:0]  i_wr_data,
  input  logic               i_rd_en,
  input  logic [ROW_AW-1:0]  i_rd_addr,
  output bundle_row_u        o_rd_row
);

  bundle_row_u mem [N_ROWS];

  logic [ROW_AW-1:0]         wr_row;
  logic [WORD_AW-ROW_AW-1:0] wr_word;

  // upper address bits pick the row, lower bits the word inside it
  assign wr_row  = i_wr_addr[WORD_AW-1 -: ROW_AW];
  assign wr_word = i_wr_addr[WORD_AW-ROW_AW-1:0];

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[wr_row].words[wr_word] <= i_wr_data;
    end
    if (i_rd_en) begin
      o_rd_row <= mem[i_rd_addr];  // whole row, one cycle latency
    end
  end

endmodule

`default_nettype wire

// ==== csr_regs.sv ====
`default_nettype none

module csr_regs import dma_pkg::*; (
  input  logic               clk,
  input  logic               rstn,
  input  logic               i_reg_wr_en,
  input  logic [ADDR_W-1:0]  i_reg_wr_addr,
  input  logic [DATA_W-1:0]  i_reg_wr_data,
  output logic               o_reg_wr_ack,
  input  logic               i_reg_rd_en,
  input  logic [ADDR_W-1:0]  i_reg_rd_addr,
  output logic               o_reg_rd_ack,
  output logic [DATA_W-1:0]  o_reg_rd_data,
  input  logic               i_o_ready,
  input  logic               i_o_valid,
  input  logic               i_o_last,
  input  logic [LEN_W-1:0]   i_o_bpt,
  input  logic [TAG_W-1:0]   i_os_tag,
  input  logic [3:0]         i_os_error,
  input  logic               i_os_valid,
  input  logic               i_od_ready,
  input  logic               i_w_idle,
  input  logic               i_x_idle,
  input  logic               i_x_waiting,
  output logic               o_start,
  output logic [CNT_W-1:0]   o_n_bundles,
  output logic [ADDR_W-1:0]  o_weights_base,
  output logic               o_bundle_done,
  output out_desc_t          o_od,
  output logic               o_ram_wr_en,
  output logic [WORD_AW-1:0] o_ram_wr_addr,
  output logic [DATA_W-1:0]  o_ram_wr_data
);

  logic [DATA_W-1:0]         cfg [A_O_DONE+1];
  logic [$clog2(N_REGS)-1:0] wr_idx;
  logic [$clog2(N_REGS)-1:0] rd_idx;
  logic                      wr_reg;
  logic                      rd_hit;
  logic                      bank;      // bank the output dma writes now
  logic                      nx_bank;
  logic                      pkt_end;   // engine finished the previous packet
  logic                      od_valid;
  logic [ADDR_W-1:0]         od_addr;
  logic                      launch;
  logic                      os_ok;
  logic [1:0]                done_read;

  assign wr_idx = i_reg_wr_addr[$clog2(N_REGS)-1:0];
  assign rd_idx = i_reg_rd_addr[$clog2(N_REGS)-1:0];
  assign wr_reg = i_reg_wr_en && i_reg_wr_addr < N_REGS && wr_idx <= A_O_DONE;
  assign rd_hit = i_reg_rd_addr < N_REGS && rd_idx <= A_O_DONE;

  assign o_reg_wr_ack  = i_reg_wr_en;
  assign o_reg_rd_ack  = i_reg_rd_en;
  assign o_reg_rd_data = rd_hit ? cfg[rd_idx] : '0;

  // table words live above the register block
  assign o_ram_wr_en   = i_reg_wr_en && i_reg_wr_addr >= SRAM_BASE
                         && i_reg_wr_addr < SRAM_BASE + N_WORDS;
  assign o_ram_wr_addr = WORD_AW'(i_reg_wr_addr - SRAM_BASE);
  assign o_ram_wr_data = i_reg_wr_data;

  assign o_start        = cfg[A_START][0];
  assign o_n_bundles    = CNT_W'(cfg[A_N_BUNDLES]);
  assign o_weights_base = cfg[A_WEIGHTS_BASE];
  assign o_bundle_done  = cfg[A_BUNDLE_DONE][0];

  assign nx_bank   = ~bank;
  assign done_read = {cfg[A_DONE_READ + 1][0], cfg[A_DONE_READ][0]};
  assign os_ok     = i_os_valid && i_os_error == '0;
  // dma wants a descriptor, engine has a new packet, host has freed the bank
  assign launch    = i_od_ready && i_o_valid && pkt_end && done_read[nx_bank];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i <= A_O_DONE; i++) begin
        cfg[i] <= '0;
      end
      cfg[A_DONE_READ]     <= DATA_W'(1);  // both banks start free
      cfg[A_DONE_READ + 1] <= DATA_W'(1);
      cfg[A_BUNDLE_DONE]   <= DATA_W'(1);
      bank     <= 1'b1;  // first launch lands on bank 0
      od_valid <= 1'b0;
      pkt_end  <= 1'b1;
    end else begin
      if (i_o_valid && i_o_ready && i_o_last) pkt_end <= 1'b1;
      if (od_valid && i_od_ready) od_valid <= 1'b0;

      if (launch) begin
        cfg[A_DONE_READ + nx_bank]  <= '0;
        cfg[A_DONE_WRITE + nx_bank] <= '0;  // bank being written again
        bank     <= nx_bank;
        od_valid <= 1'b1;
        pkt_end  <= 1'b0;
      end

      if (os_ok) cfg[A_DONE_WRITE + i_os_tag[0]] <= DATA_W'(1);

      if (o_start) cfg[A_START] <= '0;  // start is a single pulse
      if (o_bundle_done && i_x_waiting) begin
        cfg[A_BUNDLE_DONE] <= '0;  // consumed by the pixel sequencer
      end

      cfg[A_W_DONE] <= DATA_W'(i_w_idle);
      cfg[A_X_DONE] <= DATA_W'(i_x_idle);

      // output has no state of its own, infer done from last beat and status
      if (o_start || i_o_valid) cfg[A_O_DONE] <= '0;
      else if (pkt_end && os_ok) cfg[A_O_DONE] <= DATA_W'(1);

      if (wr_reg) cfg[wr_idx] <= i_reg_wr_data;  // host write wins
    end
  end

  always_ff @(posedge clk) begin
    if (launch) od_addr <= cfg[A_OCM_BASE + nx_bank];
  end

  assign o_od = '{addr: od_addr, len: i_o_bpt, tag: TAG_W'(bank), valid: od_valid};

  // a new output descriptor only targets a bank the host released
  a_bank_free: assert property (@(posedge clk) disable iff (!rstn)
    $rose(od_valid) |-> $past(done_read[~bank]));

endmodule

`default_nettype wire

// ==== dma_controller.sv ====
`default_nettype none

module dma_controller import dma_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  // host register port
  input  logic              i_reg_wr_en,
  input  logic [ADDR_W-1:0] i_reg_wr_addr,
  input  logic [DATA_W-1:0] i_reg_wr_data,
  output logic              o_reg_wr_ack,
  input  logic              i_reg_rd_en,
  input  logic [ADDR_W-1:0] i_reg_rd_addr,
  output logic              o_reg_rd_ack,
  output logic [DATA_W-1:0] o_reg_rd_data,
  // engine output stream monitor
  input  logic              i_o_ready,
  input  logic              i_o_valid,
  input  logic              i_o_last,
  input  logic [LEN_W-1:0]  i_o_bpt,
  // output dma status
  input  logic [TAG_W-1:0]  i_os_tag,
  input  logic [3:0]        i_os_error,
  input  logic              i_os_valid,
  // descriptors
  output in_desc_t          o_wd,
  input  logic              i_wd_ready,
  output in_desc_t          o_xd,
  input  logic              i_xd_ready,
  output out_desc_t         o_od,
  input  logic              i_od_ready
);

  logic                   start;
  logic                   bundle_done;
  logic [CNT_W-1:0]       n_bundles;
  logic [ADDR_W-1:0]      weights_base;
  logic                   ram_wr_en;
  logic [WORD_AW-1:0]     ram_wr_addr;
  logic [DATA_W-1:0]      ram_wr_data;
  logic                   rd_en;
  logic [ROW_AW-1:0]      rd_addr;
  bundle_row_u            rd_row;
  bundle_fields_t         fields;
  logic [1:0]             rd_req;
  logic [1:0][ROW_AW-1:0] rd_idx;
  logic [1:0]             grant;
  logic [1:0]             idle;
  logic [1:0]             waiting;
  logic [1:0]             ready;
  in_desc_t [1:0]         desc;

  csr_regs u_csr (
    .clk            (clk),
    .rstn           (rstn),
    .i_reg_wr_en    (i_reg_wr_en),
    .i_reg_wr_addr  (i_reg_wr_addr),
    .i_reg_wr_data  (i_reg_wr_data),
    .o_reg_wr_ack   (o_reg_wr_ack),
    .i_reg_rd_en    (i_reg_rd_en),
    .i_reg_rd_addr  (i_reg_rd_addr),
    .o_reg_rd_ack   (o_reg_rd_ack),
    .o_reg_rd_data  (o_reg_rd_data),
    .i_o_ready      (i_o_ready),
    .i_o_valid      (i_o_valid),
    .i_o_last       (i_o_last),
    .i_o_bpt        (i_o_bpt),
    .i_os_tag       (i_os_tag),
    .i_os_error     (i_os_error),
    .i_os_valid     (i_os_valid),
    .i_od_ready     (i_od_ready),
    .i_w_idle       (idle[STREAM_W]),
    .i_x_idle       (idle[STREAM_X]),
    .i_x_waiting    (waiting[STREAM_X]),
    .o_start        (start),
    .o_n_bundles    (n_bundles),
    .o_weights_base (weights_base),
    .o_bundle_done  (bundle_done),
    .o_od           (o_od),
    .o_ram_wr_en    (ram_wr_en),
    .o_ram_wr_addr  (ram_wr_addr),
    .o_ram_wr_data  (ram_wr_data)
  );

  bundle_ram u_ram (
    .clk       (clk),
    .i_wr_en   (ram_wr_en),
    .i_wr_addr (ram_wr_addr),
    .i_wr_data (ram_wr_data),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .o_rd_row  (rd_row)
  );

  bundle_arbiter u_arb (
    .clk           (clk),
    .rstn          (rstn),
    .i_req         (rd_req),
    .i_idx         (rd_idx),
    .i_row         (rd_row),
    .o_rd_en       (rd_en),
    .o_rd_addr     (rd_addr),
    .o_grant_valid (grant),
    .o_fields      (fields)
  );

  assign ready[STREAM_W] = i_wd_ready;
  assign ready[STREAM_X] = i_xd_ready;
  assign o_wd            = desc[STREAM_W];
  assign o_xd            = desc[STREAM_X];

  for (genvar s = 0; s < 2; s++) begin : g_seq
    input_sequencer #(
      .IS_PIXEL (s == STREAM_X)
    ) u_seq (
      .clk           (clk),
      .rstn          (rstn),
      .i_start       (start),
      .i_n_bundles   (n_bundles),
      .i_base        (weights_base),
      .i_bundle_done (bundle_done),
      .i_row_valid   (grant[s]),
      .i_fields      (fields),
      .i_ready       (ready[s]),
      .o_rd_req      (rd_req[s]),
      .o_rd_idx      (rd_idx[s]),
      .o_desc        (desc[s]),
      .o_idle        (idle[s]),
      .o_waiting     (waiting[s])
    );
  end

endmodule

`default_nettype wire

// ==== dma_pkg.sv ====
`default_nettype none

package dma_pkg;

  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int LEN_W     = 32;
  localparam int CNT_W     = 16;  // transfer, group and bundle counters
  localparam int TAG_W     = 8;
  localparam int USER_W    = 65;  // header plus first-group flag
  localparam int ROW_W     = 256;
  localparam int N_ROWS    = 8;   // bundles in the table
  localparam int N_WORDS   = 64;  // 32-bit host words behind the table
  localparam int ROW_AW    = 3;
  localparam int WORD_AW   = 6;
  localparam int N_REGS    = 16;
  localparam int SRAM_BASE = 16;  // host address of table word 0

  // register map, two-bank registers take base+0 and base+1
  localparam int A_START        = 0;
  localparam int A_DONE_READ    = 1;
  localparam int A_DONE_WRITE   = 3;
  localparam int A_OCM_BASE     = 5;
  localparam int A_WEIGHTS_BASE = 7;
  localparam int A_BUNDLE_DONE  = 8;
  localparam int A_N_BUNDLES    = 9;
  localparam int A_W_DONE       = 10;
  localparam int A_X_DONE       = 11;
  localparam int A_O_DONE       = 12;

  localparam int STREAM_W = 0;
  localparam int STREAM_X = 1;

  // input sequencer states
  localparam logic [1:0] S_IDLE       = 2'd0;
  localparam logic [1:0] S_WAIT_RAM   = 2'd1;
  localparam logic [1:0] S_WAIT_WRITE = 2'd2;  // pixel stream only
  localparam logic [1:0] S_EXEC       = 2'd3;

  typedef struct packed {
    logic [USER_W-2:0] header;
    logic [CNT_W-1:0]  max_t;
    logic [CNT_W-1:0]  max_p;
    logic [LEN_W-1:0]  w_bpt;
    logic [LEN_W-1:0]  w_bpt_p0;
    logic [LEN_W-1:0]  x_bpt;
    logic [LEN_W-1:0]  x_bpt_p0;
    logic [ADDR_W-1:0] x_base;
  } bundle_fields_t;

  // host writes words, sequencers read fields; word 0 sits in the lsbs
  typedef union packed {
    bundle_fields_t                          fields;
    logic [ROW_W/DATA_W-1:0][DATA_W-1:0]     words;
  } bundle_row_u;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [USER_W-1:0] user;
    logic              valid;
  } in_desc_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [TAG_W-1:0]  tag;
    logic              valid;
  } out_desc_t;

endpackage

`default_nettype wire

// ==== input_sequencer.sv ====
`default_nettype none

module input_sequencer import dma_pkg::*; #(
  parameter bit IS_PIXEL = 1'b0
) (
  input  logic              clk,
  input  logic              rstn,
  input  logic              i_start,
  input  logic [CNT_W-1:0]  i_n_bundles,
  input  logic [ADDR_W-1:0] i_base,
  input  logic              i_bundle_done,
  input  logic              i_row_valid,
  input  bundle_fields_t    i_fields,
  input  logic              i_ready,
  output logic              o_rd_req,
  output logic [ROW_AW-1:0] o_rd_idx,
  output in_desc_t          o_desc,
  output logic              o_idle,
  output logic              o_waiting
);

  logic [1:0]        state;
  logic [1:0]        state_nx;
  logic              start_go;
  logic              xfer;
  logic              t_last;
  logic              p_last;
  logic              b_last;
  logic              p_first;
  logic [CNT_W-1:0]  b_count;
  logic [USER_W-2:0] header;
  logic [LEN_W-1:0]  bpt;
  logic [LEN_W-1:0]  bpt_p0;
  logic [LEN_W-1:0]  len;
  logic [ADDR_W-1:0] addr;

  assign start_go = i_start && state == S_IDLE;

  always_comb begin
    state_nx = state;
    case (state)
      S_IDLE:       if (start_go) state_nx = S_WAIT_RAM;
      S_WAIT_RAM:   if (i_row_valid) state_nx = IS_PIXEL ? S_WAIT_WRITE : S_EXEC;
      S_WAIT_WRITE: if (i_bundle_done) state_nx = S_EXEC;  // previous output consumed
      default: begin
        if (b_last) begin
          state_nx = S_IDLE;
        end else if (p_last) begin
          state_nx = S_WAIT_RAM;  // fetch the next bundle row
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) state <= S_IDLE;
    else       state <= state_nx;
  end

  // held only until the row comes back, so a lost request repeats
  assign o_rd_req  = state == S_WAIT_RAM && !i_row_valid;
  assign o_rd_idx  = ROW_AW'(i_n_bundles - 1'b1 - b_count);  // bundle counter runs down
  assign o_idle    = state == S_IDLE;
  assign o_waiting = state == S_WAIT_WRITE;

  always_ff @(posedge clk) begin
    if (i_row_valid) begin
      header <= i_fields.header;
      bpt    <= IS_PIXEL ? i_fields.x_bpt    : i_fields.w_bpt;
      bpt_p0 <= IS_PIXEL ? i_fields.x_bpt_p0 : i_fields.w_bpt_p0;
    end
  end

  // weights walk every transfer, pixels step once per group
  always_ff @(posedge clk) begin
    if (IS_PIXEL) begin
      if (i_row_valid) addr <= i_fields.x_base;
      else if (t_last) addr <= addr + len;
    end else begin
      if (start_go)  addr <= i_base;
      else if (xfer) addr <= addr + len;
    end
  end

  assign len    = p_first ? bpt_p0 : bpt;
  assign o_desc = '{addr: addr, len: len, user: {header, p_first}, valid: state == S_EXEC};
  assign xfer   = o_desc.valid && i_ready;

  nested_counter u_xfer_cnt (
    .clk        (clk),
    .rstn       (rstn),
    .i_load     (i_row_valid),
    .i_en       (xfer),
    .i_max      (i_fields.max_t - 1'b1),
    .o_count    (),
    .o_last     (),
    .o_last_clk (t_last),
    .o_first    ()
  );

  nested_counter u_group_cnt (
    .clk        (clk),
    .rstn       (rstn),
    .i_load     (i_row_valid),
    .i_en       (t_last),
    .i_max      (i_fields.max_p - 1'b1),
    .o_count    (),
    .o_last     (),
    .o_last_clk (p_last),
    .o_first    (p_first)
  );

  nested_counter u_bundle_cnt (
    .clk        (clk),
    .rstn       (rstn),
    .i_load     (start_go),
    .i_en       (p_last),
    .i_max      (i_n_bundles - 1'b1),
    .o_count    (b_count),
    .o_last     (),
    .o_last_clk (b_last),
    .o_first    ()
  );

  a_hold_valid: assert property (@(posedge clk) disable iff (!rstn)
    o_desc.valid && !i_ready |=> o_desc.valid && $stable(o_desc));

  // pixel requests never come back to back, so one retry is the worst case
  a_rd_answered: assert property (@(posedge clk) disable iff (!rstn)
    $rose(o_rd_req) |-> ##[1:2] i_row_valid);

  a_max_p: assert property (@(posedge clk) disable iff (!rstn)
    i_row_valid |-> i_fields.max_p != '0);

endmodule

`default_nettype wire

// ==== nested_counter.sv ====
`default_nettype none

module nested_counter import dma_pkg::*; (
  input  logic             clk,
  input  logic             rstn,
  input  logic             i_load,
  input  logic             i_en,
  input  logic [CNT_W-1:0] i_max,
  output logic [CNT_W-1:0] o_count,
  output logic             o_last,
  output logic             o_last_clk,
  output logic             o_first
);

  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] max_q;  // reload value kept for the wrap

  always_ff @(posedge clk) begin
    if (!rstn) begin
      count <= '0;
      max_q <= '0;
    end else if (i_load) begin
      count <= i_max;
      max_q <= i_max;
    end else if (i_en) begin
      count <= (count == '0) ? max_q : count - 1'b1;  // wrap for the next outer step
    end
  end

  assign o_count    = count;
  assign o_last     = count == '0;
  assign o_last_clk = o_last && i_en;  // steps the next counter up
  assign o_first    = count == max_q;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the testbench, pass only if the log holds the pass message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dma_controller \
  -f vlog.f -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "PASS: all tests" sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== tb_dma_controller.sv ====
`default_nettype none

module tb_dma_controller import dma_pkg::*;;

  // worst case is 3 bundles of 4 x 3 transfers, two streams, two runs
  localparam int MAX_XFERS  = 3 * 4 * 3 * 2 * 2;
  localparam int WDOG_CYCLS = MAX_XFERS * 40 + 2000;

  logic              clk;
  logic              rstn;
  logic              i_reg_wr_en;
  logic [ADDR_W-1:0] i_reg_wr_addr;
  logic [DATA_W-1:0] i_reg_wr_data;
  logic              o_reg_wr_ack;
  logic              i_reg_rd_en;
  logic [ADDR_W-1:0] i_reg_rd_addr;
  logic              o_reg_rd_ack;
  logic [DATA_W-1:0] o_reg_rd_data;
  logic              i_o_ready;
  logic              i_o_valid;
  logic              i_o_last;
  logic [LEN_W-1:0]  i_o_bpt;
  logic [TAG_W-1:0]  i_os_tag;
  logic [3:0]        i_os_error;
  logic              i_os_valid;
  in_desc_t          o_wd;
  logic              i_wd_ready;
  in_desc_t          o_xd;
  logic              i_xd_ready;
  out_desc_t         o_od;
  logic              i_od_ready;

  logic [31:0] rng;
  int          errors;
  int          checks;
  int          tests;
  int          tests_failed;
  int          w_mode;    // 0 low, 1 random, 2 high
  int          x_mode;
  int          w_got;
  int          x_got;
  int          released;  // pixel bundles the host has let through
  logic [31:0] last_x_addr;

  bundle_row_u rows [N_ROWS];
  in_desc_t    exp_w [$];
  in_desc_t    exp_x [$];
  int          exp_bnd_x [$];
  int          exp_grp_x [$];
  out_desc_t   od_seen [$];

  dma_controller u_dut (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  // builds the expected descriptor list of one stream from the table rules
  function automatic void build_expected(input int s, input int n, input logic [31:0] base);
    logic [31:0] addr;
    logic [31:0] len;
    in_desc_t    d;
    addr = base;
    for (int b = 0; b < n; b++) begin
      if (s == STREAM_X) addr = rows[b].fields.x_base;
      for (int p = 0; p < rows[b].fields.max_p; p++) begin
        if (s == STREAM_X) len = (p == 0) ? rows[b].fields.x_bpt_p0 : rows[b].fields.x_bpt;
        else               len = (p == 0) ? rows[b].fields.w_bpt_p0 : rows[b].fields.w_bpt;
        for (int t = 0; t < rows[b].fields.max_t; t++) begin
          d.addr  = addr;
          d.len   = len;
          d.user  = {rows[b].fields.header, p == 0};
          d.valid = 1'b1;
          if (s == STREAM_X) begin
            exp_x.push_back(d);
            exp_bnd_x.push_back(b);
            exp_grp_x.push_back(p);
          end else begin
            exp_w.push_back(d);
            addr = addr + len;  // weights advance every transfer
          end
        end
        if (s == STREAM_X) addr = addr + len;  // pixels advance per group
      end
    end
  endfunction

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    i_reg_wr_en   <= 1'b1;
    i_reg_wr_addr <= addr;
    i_reg_wr_data <= data;
    @(negedge clk);
    check("o_reg_wr_ack", o_reg_wr_ack, 1'b1);
    @(posedge clk);
    i_reg_wr_en   <= 1'b0;
  endtask

  task automatic reg_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk);
    i_reg_rd_en   <= 1'b1;
    i_reg_rd_addr <= addr;
    @(negedge clk);
    data = o_reg_rd_data;  // combinational read is sampled mid cycle
    check("o_reg_rd_ack", o_reg_rd_ack, 1'b1);
    @(posedge clk);
    i_reg_rd_en   <= 1'b0;
  endtask

  task automatic expect_reg(input string name, input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] v;
    reg_read(addr, v);
    check(name, v, exp);
  endtask

  // polls a status register until it reads 1
  task automatic wait_flag(input string name, input logic [31:0] addr);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < 20 && v != 1; i++) reg_read(addr, v);
    if (v != 1) note_failure({name, " did not return to 1"});
  endtask

  task automatic make_table(input int n);
    for (int b = 0; b < n; b++) begin
      rows[b].fields.header   = {next_rand(), next_rand()};
      rows[b].fields.max_t    = CNT_W'(1 + next_rand() % 4);
      rows[b].fields.max_p    = CNT_W'(1 + next_rand() % 3);
      rows[b].fields.w_bpt    = 1 + next_rand() % 1024;
      rows[b].fields.w_bpt_p0 = 1 + next_rand() % 1024;
      rows[b].fields.x_bpt    = 1 + next_rand() % 1024;
      rows[b].fields.x_bpt_p0 = 1 + next_rand() % 1024;
      rows[b].fields.x_base   = next_rand() & 32'hffff_ff00;
      for (int w = 0; w < ROW_W / DATA_W; w++) begin
        reg_write(SRAM_BASE + 8 * b + w, rows[b].words[w]);
      end
    end
  endtask

  task automatic setup_run(input int n, input logic [31:0] base);
    exp_w.delete();
    exp_x.delete();
    exp_bnd_x.delete();
    exp_grp_x.delete();
    w_got = 0;
    x_got = 0;
    make_table(n);
    reg_write(A_N_BUNDLES, n);
    reg_write(A_WEIGHTS_BASE, base);
    build_expected(STREAM_W, n, base);
    build_expected(STREAM_X, n, base);
  endtask

  task automatic start_run();
    reg_write(A_START, 1);
    expect_reg("A_START after pulse", A_START, 0);
  endtask

  // lets pixel bundle k go once bundle k-1 has been fully issued
  task automatic release_bundles(input int n);
    int c;
    for (int k = 1; k < n; k++) begin
      c = 0;
      foreach (exp_bnd_x[i]) if (exp_bnd_x[i] < k) c++;
      wait (x_got >= c);
      repeat (next_rand() % 8) @(posedge clk);
      reg_write(A_BUNDLE_DONE, 1);
      released <= k + 1;
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests, name, errors - err_before);
    end
  endtask

  always @(posedge clk) begin
    i_wd_ready <= (w_mode == 2) || (w_mode == 1 && next_rand() % 3 != 0);
    i_xd_ready <= (x_mode == 2) || (x_mode == 1 && next_rand() % 3 != 0);
  end

  // values are sampled at the edge where the transfer happens
  always @(posedge clk) begin
    if (rstn && o_wd.valid && i_wd_ready) begin
      if (w_got >= exp_w.size()) begin
        note_failure("weights descriptor issued beyond the expected list");
      end else begin
        check("o_wd.addr", o_wd.addr, exp_w[w_got].addr);
        check("o_wd.len", o_wd.len, exp_w[w_got].len);
        check("o_wd.user", o_wd.user, exp_w[w_got].user);
      end
      w_got++;
    end
    if (rstn && o_xd.valid && i_xd_ready) begin
      if (x_got >= exp_x.size()) begin
        note_failure("pixel descriptor issued beyond the expected list");
      end else begin
        if (exp_bnd_x[x_got] >= released) begin
          note_failure("pixel descriptor issued before its bundle was released");
        end
        if (x_got > 0 && exp_bnd_x[x_got] == exp_bnd_x[x_got-1]
            && exp_grp_x[x_got] == exp_grp_x[x_got-1]) begin
          check("o_xd.addr within group", o_xd.addr, last_x_addr);
        end
        check("o_xd.addr", o_xd.addr, exp_x[x_got].addr);
        check("o_xd.len", o_xd.len, exp_x[x_got].len);
        check("o_xd.user", o_xd.user, exp_x[x_got].user);
      end
      last_x_addr = o_xd.addr;
      x_got++;
    end
    if (rstn && o_od.valid && i_od_ready) od_seen.push_back(o_od);
  end

  initial begin
    repeat (WDOG_CYCLS) @(posedge clk);
    $display("ERROR t=%0t watchdog expired before the tests finished", $time);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    int e;
    int n;
    clk = 1'b0;
    rstn = 1'b0;
    rng = 32'd71335;
    i_reg_wr_en = 1'b0;
    i_reg_wr_addr = '0;
    i_reg_wr_data = '0;
    i_reg_rd_en = 1'b0;
    i_reg_rd_addr = '0;
    i_o_ready = 1'b0;
    i_o_valid = 1'b0;
    i_o_last = 1'b0;
    i_o_bpt = '0;
    i_os_tag = '0;
    i_os_error = '0;
    i_os_valid = 1'b0;
    i_wd_ready = 1'b0;
    i_xd_ready = 1'b0;
    i_od_ready = 1'b0;
    w_mode = 0;
    x_mode = 0;
    released = 1;  // bundle done reads 1 out of reset
    repeat (10) @(posedge clk);
    rstn <= 1'b1;
    repeat (3) @(posedge clk);

    e = errors;
    for (int a = 0; a <= A_O_DONE; a++) begin
      expect_reg($sformatf("reset value of reg %0d", a), a,
                 (a inside {1, 2, A_BUNDLE_DONE, A_W_DONE, A_X_DONE}) ? 1 : 0);
    end
    reg_write(A_OCM_BASE, 32'h4000_0000);
    expect_reg("A_OCM_BASE bank 0", A_OCM_BASE, 32'h4000_0000);
    reg_write(A_OCM_BASE + 1, 32'h4800_0000);
    expect_reg("A_OCM_BASE bank 1", A_OCM_BASE + 1, 32'h4800_0000);
    reg_write(A_N_BUNDLES, 3);
    expect_reg("A_N_BUNDLES", A_N_BUNDLES, 3);
    expect_reg("read above registers", 20, 0);
    finish_test("registers", e);

    // weights run first while pixels are held off
    e = errors;
    n = 2 + next_rand() % 2;
    setup_run(n, 32'h1000_0000 + (next_rand() & 32'hfff0));
    w_mode = 1;
    start_run();
    wait (w_got >= exp_w.size());
    wait_flag("A_W_DONE", A_W_DONE);
    finish_test("weights stream", e);

    e = errors;
    x_mode = 1;
    release_bundles(n);
    wait (x_got >= exp_x.size());
    wait_flag("A_X_DONE", A_X_DONE);
    finish_test("pixels stream", e);

    // second run lets both streams contend for the table
    e = errors;
    n = 2 + next_rand() % 2;
    setup_run(n, 32'h2000_0000 + (next_rand() & 32'hfff0));
    released = 0;
    reg_write(A_BUNDLE_DONE, 1);
    released = 1;
    start_run();
    release_bundles(n);
    wait (w_got >= exp_w.size() && x_got >= exp_x.size());
    wait_flag("A_W_DONE", A_W_DONE);
    wait_flag("A_X_DONE", A_X_DONE);
    check("weights count", w_got, exp_w.size());
    check("pixels count", x_got, exp_x.size());
    finish_test("both streams", e);

    e = errors;
    @(posedge clk);
    i_o_bpt    <= 32'h0000_0300;
    i_o_valid  <= 1'b1;
    i_o_ready  <= 1'b1;
    i_od_ready <= 1'b1;
    wait (od_seen.size() >= 1);
    expect_reg("A_DONE_READ bank 0 after launch", A_DONE_READ, 0);
    @(posedge clk);
    i_o_last <= 1'b1;
    @(posedge clk);
    i_o_last <= 1'b0;
    wait (od_seen.size() >= 2);
    @(posedge clk);
    i_o_last <= 1'b1;
    @(posedge clk);
    i_o_last <= 1'b0;
    repeat (10) @(posedge clk);
    if (od_seen.size() != 2) note_failure("third output descriptor not held for bank 0");
    reg_write(A_DONE_READ, 1);
    wait (od_seen.size() >= 3);
    check("o_od.addr 0", od_seen[0].addr, 32'h4000_0000);
    check("o_od.tag 0", od_seen[0].tag, 0);
    check("o_od.len 0", od_seen[0].len, 32'h0000_0300);
    check("o_od.addr 1", od_seen[1].addr, 32'h4800_0000);
    check("o_od.tag 1", od_seen[1].tag, 1);
    check("o_od.addr 2", od_seen[2].addr, 32'h4000_0000);
    check("o_od.tag 2", od_seen[2].tag, 0);
    @(posedge clk);
    i_o_last <= 1'b1;
    @(posedge clk);
    i_o_last  <= 1'b0;
    i_o_valid <= 1'b0;
    @(posedge clk);
    i_os_valid <= 1'b1;
    i_os_tag   <= 8'd0;
    @(posedge clk);
    i_os_valid <= 1'b0;
    expect_reg("A_DONE_WRITE bank 0", A_DONE_WRITE, 1);
    expect_reg("A_O_DONE", A_O_DONE, 1);
    finish_test("output ping-pong", e);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
dma_pkg.sv
bundle_ram.sv
nested_counter.sv
bundle_arbiter.sv
input_sequencer.sv
csr_regs.sv
dma_controller.sv
tb_dma_controller.sv
